// ==== audio_mix_chan.sv ====
/*
 * One audio channel. Glitch filter on the core sample,
 * format conversion, Linux PCM add, attenuation and clamp
 */
`timescale 1ns/100ps
`default_nettype none

module audio_mix_chan (
	input  wire                             clk_sys,
	input  wire                             resetd,
	input  wire sys_hal_pkg::audio_sample_t i_core,
	input  wire                             i_core_signed,
	input  wire sys_hal_pkg::audio_sample_t i_linux,
	input  wire sys_hal_pkg::att_t          i_att,
	output sys_hal_pkg::audio_sample_t      o_audio
);
	import sys_hal_pkg::*;

	audio_sample_t      d1;
	audio_sample_t      d2;
	audio_sample_t      d3;
	audio_sample_t      ca;
	audio_sample_t      lin_d1;
	audio_sample_t      lin_d2;
	logic signed [16:0] a1;
	logic signed [16:0] a2;
	logic signed [16:0] a3;
	logic signed [16:0] a4;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			d1      <= '0;
			d2      <= '0;
			d3      <= '0;
			ca      <= '0;
			lin_d1  <= '0;
			lin_d2  <= '0;
			a1      <= '0;
			a2      <= '0;
			a3      <= '0;
			a4      <= '0;
			o_audio <= '0;
		end else begin
			// Glitch filter, value must hold for two cycles
			d1 <= i_core;
			d2 <= d1;
			d3 <= d2;
			if (d2 == d3) ca <= d2;

			lin_d1 <= i_linux;
			lin_d2 <= lin_d1;

			// Unsigned core sample drops to 15 bits, zero filled
			a1 <= i_core_signed ? {ca[15], ca} : {2'b00, ca[15:1]};
			a2 <= a1 + $signed({lin_d2[15], lin_d2});

			// Mix stage, single channel mode
			a3 <= a2;

			if (i_att[4]) begin
				a4 <= '0;
			end else begin
				a4 <= a3 >>> i_att[3:0];
			end

			// Saturate to the 16-bit signed range
			if (a4[16] != a4[15]) begin
				o_audio <= {a4[16], {15{a4[15]}}};
			end else begin
				o_audio <= a4[15:0];
			end
		end
	end

endmodule

`default_nettype wire

// ==== cfg_led_ctrl.sv ====
/*
 * Configuration registers loaded by host commands
 * (config word, LED overtake, volume) and LED composition
 */
`timescale 1ns/100ps
`default_nettype none

module cfg_led_ctrl (
	input  wire                        clk_sys,
	input  wire                        resetd,
	input  wire                        i_cmd_valid,
	input  wire sys_hal_pkg::cmd_t     i_cmd_code,
	input  wire sys_hal_pkg::io_word_t i_cmd_data,
	input  wire                        i_led_user,
	input  wire [1:0]                  i_led_power,
	input  wire                        i_led_disk,
	output logic                       o_csync_en,
	output sys_hal_pkg::att_t          o_vol_att,
	output logic                       o_led_power,
	output logic                       o_led_hdd,
	output logic                       o_led_user,
	output sys_hal_pkg::led_byte_t     o_led_board
);
	import sys_hal_pkg::*;

	io_word_t  cfg_word;
	led_byte_t led_mask;
	led_byte_t led_state;
	led_byte_t led_dflt;
	logic      led_p;
	logic      led_d;
	logic      led_u;

	////////////////////////////////////////////////////////////
	// Command decode
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			cfg_word  <= '0;
			led_mask  <= '0;
			led_state <= '0;
			o_vol_att <= '0;
		end else if (i_cmd_valid) begin
			case (i_cmd_code)
				CMD_CFG: cfg_word <= i_cmd_data;
				// Mask in the high byte, state in the low byte
				CMD_LED: {led_mask, led_state} <= i_cmd_data;
				CMD_VOL: o_vol_att <= i_cmd_data[4:0];
				default: ;
			endcase
		end
	end

	assign o_csync_en = cfg_word[CFG_CSYNC_BIT];

	////////////////////////////////////////////////////////////
	// LED composition
	////////////////////////////////////////////////////////////

	// Power lit only with both status bits set
	assign led_p = i_led_power[1] & i_led_power[0];
	assign led_d = i_led_disk;
	assign led_u = i_led_user;

	assign o_led_power = led_p;
	assign o_led_hdd   = led_d;
	assign o_led_user  = led_u;

	assign led_dflt = {3'b000, led_p, 1'b0, led_d, 1'b0, led_u};

	// Host overtakes the bits selected by the mask
	assign o_led_board = (led_mask & led_state) | (~led_mask & led_dflt);

endmodule

`default_nettype wire

// ==== hps_cmd_port.sv ====
/*
 * Host command port. Synchronises the strobe, frame enable
 * and data lines, returns the acknowledge and splits each
 * frame into a command word and its data words
 */
`timescale 1ns/100ps
`default_nettype none

module hps_cmd_port (
	input  wire                   clk_sys,
	input  wire                   resetd,
	input  wire                   i_io_clk,
	input  wire                   i_io_uio,
	input  wire sys_hal_pkg::io_word_t i_io_din,
	output logic                  o_io_ack,
	output logic                  o_cmd_valid,
	output sys_hal_pkg::cmd_t     o_cmd_code,
	output sys_hal_pkg::io_word_t o_cmd_data
);
	import sys_hal_pkg::*;

	typedef enum logic {PH_CMD, PH_DATA} phase_t;

	logic     clk_s1;
	logic     clk_s2;
	logic     clk_s3;
	logic     uio_s1;
	logic     uio_s2;
	logic     ack_d;
	io_word_t din_s1;
	io_word_t din_s2;
	phase_t   phase;
	logic     strobe;

	// Rising edge of the synchronised strobe
	assign strobe = clk_s2 & ~clk_s3;

	////////////////////////////////////////////////////////////
	// Synchronisers and acknowledge
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_s1   <= 1'b0;
			clk_s2   <= 1'b0;
			clk_s3   <= 1'b0;
			uio_s1   <= 1'b0;
			uio_s2   <= 1'b0;
			ack_d    <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			clk_s1   <= i_io_clk;
			clk_s2   <= clk_s1;
			clk_s3   <= clk_s2;
			uio_s1   <= i_io_uio;
			uio_s2   <= uio_s1;
			// Ack trails the synchronised strobe level by two cycles
			ack_d    <= clk_s2;
			o_io_ack <= ack_d;
		end
	end

	// Data word follows the same two stages
	always_ff @(posedge clk_sys) begin
		din_s1 <= i_io_din;
		din_s2 <= din_s1;
	end

	////////////////////////////////////////////////////////////
	// Framing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			phase       <= PH_CMD;
			o_cmd_valid <= 1'b0;
			o_cmd_code  <= '0;
		end else begin
			o_cmd_valid <= 1'b0;
			if (!uio_s2) begin
				phase <= PH_CMD;
			end else if (strobe) begin
				if (phase == PH_CMD) begin
					o_cmd_code <= din_s2[7:0];
					phase      <= PH_DATA;
				end else begin
					o_cmd_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (uio_s2 && strobe && phase == PH_DATA) begin
			o_cmd_data <= din_s2;
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the testbench with Verilator, run it and search the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
	-f sys_top.f --top-module tb_sys_top -Mdir obj_dir -o tb_sys_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sys_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sync_polarity_fix.sv ====
/*
 * Sync polarity detector. Times the high and low phases
 * and drives the short phase as the active-high pulse
 */
`timescale 1ns/100ps
`default_nettype none

module sync_polarity_fix #(
	parameter int SYNC_CNT_W = sys_hal_pkg::SYNC_CNT_W_DEF
) (
	input  wire  clk_sys,
	input  wire  resetd,
	input  wire  i_sync,
	output logic o_sync
);
	logic                  sync_q;
	logic                  sync_qq;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] high_len;
	logic [SYNC_CNT_W-1:0] low_len;
	logic                  pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sync_q   <= 1'b0;
			sync_qq  <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
			pol      <= 1'b0;
		end else begin
			sync_q  <= i_sync;
			sync_qq <= sync_q;

			// Cycles since the last edge, held at full scale
			if (sync_q != sync_qq) begin
				cnt <= '0;
			end else if (~&cnt) begin
				cnt <= cnt + 1'b1;
			end

			if (sync_q & ~sync_qq) low_len <= cnt;
			if (~sync_q & sync_qq) high_len <= cnt;

			pol <= high_len > low_len;
		end
	end

	assign o_sync = sync_q ^ pol;

endmodule

`default_nettype wire

// ==== sys_hal_pkg.sv ====
/*
 * Shared widths and data types for the system block,
 * host command codes and configuration word bit positions
 */
`default_nettype none

package sys_hal_pkg;

	////////////////////////////////////////////////////////////
	// Data types
	////////////////////////////////////////////////////////////

	// Host word, 16 bits per strobe
	typedef logic [15:0] io_word_t;

	// Command code, low byte of the first word in a frame
	typedef logic [7:0]  cmd_t;

	// Audio sample, signed at the output
	typedef logic [15:0] audio_sample_t;

	// Bit 4 mutes, bits 3..0 give the right shift
	typedef logic [4:0]  att_t;

	typedef logic [7:0]  led_byte_t;

	////////////////////////////////////////////////////////////
	// Command codes and configuration bits
	////////////////////////////////////////////////////////////

	localparam cmd_t CMD_CFG = 8'h01;
	localparam cmd_t CMD_LED = 8'h25;
	localparam cmd_t CMD_VOL = 8'h26;

	// Composite sync enable in the configuration word
	localparam int CFG_CSYNC_BIT = 3;

	// Sync phase counters
	localparam int SYNC_CNT_W_DEF = 12;

endpackage

`default_nettype wire

// ==== sys_top.f ====
sys_hal_pkg.sv
hps_cmd_port.sv
cfg_led_ctrl.sv
sync_polarity_fix.sv
video_sync_out.sv
audio_mix_chan.sv
sys_top.sv
tb_sys_top.sv

// ==== sys_top.sv ====
/*
 * System top level. Host command port, configuration and
 * LED block, VGA sync output and the two audio channels
 */
`timescale 1ns/100ps
`default_nettype none

module sys_top #(
	parameter int SYNC_CNT_W = sys_hal_pkg::SYNC_CNT_W_DEF
) (
	input  wire                             clk_sys,
	input  wire                             resetd,
	input  wire                             i_io_clk,
	input  wire                             i_io_uio,
	input  wire sys_hal_pkg::io_word_t      i_io_din,
	input  wire                             i_led_user,
	input  wire [1:0]                       i_led_power,
	input  wire                             i_led_disk,
	input  wire                             i_audio_signed,
	input  wire sys_hal_pkg::audio_sample_t i_core_l,
	input  wire sys_hal_pkg::audio_sample_t i_core_r,
	input  wire sys_hal_pkg::audio_sample_t i_linux_l,
	input  wire sys_hal_pkg::audio_sample_t i_linux_r,
	input  wire                             i_hs,
	input  wire                             i_vs,
	output logic                            o_io_ack,
	output logic                            o_led_power,
	output logic                            o_led_hdd,
	output logic                            o_led_user,
	output sys_hal_pkg::led_byte_t          o_led_board,
	output sys_hal_pkg::audio_sample_t      o_audio_l,
	output sys_hal_pkg::audio_sample_t      o_audio_r,
	output logic                            o_vga_hs,
	output logic                            o_vga_vs
);
	import sys_hal_pkg::*;

	logic     cmd_valid;
	cmd_t     cmd_code;
	io_word_t cmd_data;
	att_t     vol_att;
	logic     csync_en;

	////////////////////////////////////////////////////////////
	// Host side
	////////////////////////////////////////////////////////////

	hps_cmd_port i_hps_cmd_port (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_clk    (i_io_clk),
		.i_io_uio    (i_io_uio),
		.i_io_din    (i_io_din),
		.o_io_ack    (o_io_ack),
		.o_cmd_valid (cmd_valid),
		.o_cmd_code  (cmd_code),
		.o_cmd_data  (cmd_data)
	);

	cfg_led_ctrl i_cfg_led_ctrl (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_cmd_valid (cmd_valid),
		.i_cmd_code  (cmd_code),
		.i_cmd_data  (cmd_data),
		.i_led_user  (i_led_user),
		.i_led_power (i_led_power),
		.i_led_disk  (i_led_disk),
		.o_csync_en  (csync_en),
		.o_vol_att   (vol_att),
		.o_led_power (o_led_power),
		.o_led_hdd   (o_led_hdd),
		.o_led_user  (o_led_user),
		.o_led_board (o_led_board)
	);

	////////////////////////////////////////////////////////////
	// Video and audio outputs
	////////////////////////////////////////////////////////////

	video_sync_out #(.SYNC_CNT_W(SYNC_CNT_W)) i_video_sync_out (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_hs       (i_hs),
		.i_vs       (i_vs),
		.i_csync_en (csync_en),
		.o_vga_hs   (o_vga_hs),
		.o_vga_vs   (o_vga_vs)
	);

	audio_mix_chan i_audio_mix_l (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_core        (i_core_l),
		.i_core_signed (i_audio_signed),
		.i_linux       (i_linux_l),
		.i_att         (vol_att),
		.o_audio       (o_audio_l)
	);

	audio_mix_chan i_audio_mix_r (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_core        (i_core_r),
		.i_core_signed (i_audio_signed),
		.i_linux       (i_linux_r),
		.i_att         (vol_att),
		.o_audio       (o_audio_r)
	);

endmodule

`default_nettype wire

// ==== tb_sys_top.sv ====
/*
 * Testbench for the system top level. Host frame tasks,
 * stimulus table with expected audio, LED and sync values,
 * sync generator, output checks and run timeout
 */
`timescale 1ns/100ps
`default_nettype none

module tb_sys_top;
	import sys_hal_pkg::*;

	localparam int N_ROWS         = 15;
	localparam int TIMEOUT_CYCLES = N_ROWS * 80 + 400;
	localparam int ACK_LIMIT      = 20;
	localparam int SETTLE         = 12;
	// Active-low sync timing in clock cycles
	localparam int HS_PER = 16;
	localparam int HS_LOW = 2;
	localparam int VS_PER = 48;
	localparam int VS_LOW = 6;
	// Rows with this command send no frame
	localparam logic [7:0] NO_CMD = 8'h00;

	typedef struct packed {
		logic [7:0]  cmd;
		logic [15:0] data;
		logic [15:0] core_l;
		logic [15:0] core_r;
		logic [15:0] lin_l;
		logic [15:0] lin_r;
		logic        sgn;
		logic        led_u;
		logic [1:0]  led_p;
		logic        led_d;
		logic        glitch_en;
		logic [15:0] glitch;
		logic        chk_sync;
		logic [15:0] exp_l;
		logic [15:0] exp_r;
		logic [7:0]  exp_board;
		logic        exp_csync;
	} row_t;

	logic        clk_sys;
	logic        resetd;
	logic        i_io_clk;
	logic        i_io_uio;
	logic [15:0] i_io_din;
	logic        i_led_user;
	logic [1:0]  i_led_power;
	logic        i_led_disk;
	logic        i_audio_signed;
	logic [15:0] i_core_l;
	logic [15:0] i_core_r;
	logic [15:0] i_linux_l;
	logic [15:0] i_linux_r;
	logic        i_hs;
	logic        i_vs;
	logic        o_io_ack;
	logic        o_led_power;
	logic        o_led_hdd;
	logic        o_led_user;
	logic [7:0]  o_led_board;
	logic [15:0] o_audio_l;
	logic [15:0] o_audio_r;
	logic        o_vga_hs;
	logic        o_vga_vs;

	row_t        rows [N_ROWS];
	int          n_rows = 0;
	int          cur_row = 0;
	int          val_errors = 0;
	int          hs_errors = 0;
	int          timeouts = 0;
	int          cycles = 0;
	int          gcnt;
	logic        hs_prev;
	logic        vs_prev;
	// Register contents expected in the DUT
	logic [15:0] m_cfg = '0;
	logic [7:0]  m_mask = '0;
	logic [7:0]  m_state = '0;
	logic [4:0]  m_att = '0;

	sys_top i_sys_top (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.i_io_clk       (i_io_clk),
		.i_io_uio       (i_io_uio),
		.i_io_din       (i_io_din),
		.i_led_user     (i_led_user),
		.i_led_power    (i_led_power),
		.i_led_disk     (i_led_disk),
		.i_audio_signed (i_audio_signed),
		.i_core_l       (i_core_l),
		.i_core_r       (i_core_r),
		.i_linux_l      (i_linux_l),
		.i_linux_r      (i_linux_r),
		.i_hs           (i_hs),
		.i_vs           (i_vs),
		.o_io_ack       (o_io_ack),
		.o_led_power    (o_led_power),
		.o_led_hdd      (o_led_hdd),
		.o_led_user     (o_led_user),
		.o_led_board    (o_led_board),
		.o_audio_l      (o_audio_l),
		.o_audio_r      (o_audio_r),
		.o_vga_hs       (o_vga_hs),
		.o_vga_vs       (o_vga_vs)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Free running active-low hs and vs, previous values kept
	initial begin
		gcnt    = 0;
		i_hs    = 1'b1;
		i_vs    = 1'b1;
		hs_prev = 1'b1;
		vs_prev = 1'b1;
		forever begin
			@(posedge clk_sys);
			#2;
			hs_prev = i_hs;
			vs_prev = i_vs;
			gcnt    = (gcnt + 1) % VS_PER;
			i_hs    = !((gcnt % HS_PER) < HS_LOW);
			i_vs    = !(gcnt < VS_LOW);
		end
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic [15:0] audio_model(input logic [15:0] core, input logic sgn,
		input logic [15:0] lin, input logic [4:0] att);
		int c;
		int s;
		if (sgn) c = int'($signed(core));
		else c = int'(core) >>> 1;
		s = c + int'($signed(lin));
		if (att[4]) s = 0;
		else s = s >>> att[3:0];
		if (s > 32767) s = 32767;
		else if (s < -32768) s = -32768;
		return s[15:0];
	endfunction

	function automatic logic [7:0] board_model(input logic [7:0] mask, input logic [7:0] state,
		input logic u, input logic [1:0] p, input logic d);
		logic [7:0] dflt;
		logic [7:0] b;
		int         i;
		dflt    = 8'h00;
		dflt[4] = p[1] & p[0];
		dflt[2] = d;
		dflt[0] = u;
		for (i = 0; i < 8; i++) b[i] = mask[i] ? state[i] : dflt[i];
		return b;
	endfunction

	task automatic add_row(input logic [7:0] cmd, input logic [15:0] data,
		input logic [15:0] core_l, input logic [15:0] core_r,
		input logic [15:0] lin_l, input logic [15:0] lin_r, input logic sgn,
		input logic [3:0] leds, input logic glitch_en, input logic [15:0] glitch,
		input logic chk_sync);
		row_t r;
		case (cmd)
			CMD_CFG: m_cfg = data;
			CMD_LED: begin
				m_mask  = data[15:8];
				m_state = data[7:0];
			end
			CMD_VOL: m_att = data[4:0];
			default: ;
		endcase
		r.cmd       = cmd;
		r.data      = data;
		r.core_l    = core_l;
		r.core_r    = core_r;
		r.lin_l     = lin_l;
		r.lin_r     = lin_r;
		r.sgn       = sgn;
		// LED inputs packed as user, power[1:0], disk
		r.led_u     = leds[3];
		r.led_p     = leds[2:1];
		r.led_d     = leds[0];
		r.glitch_en = glitch_en;
		r.glitch    = glitch;
		r.chk_sync  = chk_sync;
		r.exp_l     = audio_model(core_l, sgn, lin_l, m_att);
		r.exp_r     = audio_model(core_r, sgn, lin_r, m_att);
		r.exp_board = board_model(m_mask, m_state, leds[3], leds[2:1], leds[0]);
		r.exp_csync = m_cfg[CFG_CSYNC_BIT];
		rows[n_rows] = r;
		n_rows++;
	endtask

	task automatic build_table;
		// Signed mix, then shifts 3 and 15, then mute
		add_row(NO_CMD, 16'h0000, 16'h1000, 16'hF000, 16'h0234, 16'hFF00, 1'b1, 4'b1110,
			1'b0, 16'h0000, 1'b0);
		add_row(CMD_VOL, 16'h0003, 16'h1000, 16'hF000, 16'h0234, 16'hFF00, 1'b1, 4'b1110,
			1'b0, 16'h0000, 1'b0);
		add_row(CMD_VOL, 16'h000F, 16'h7000, 16'h9000, 16'h1000, 16'hF000, 1'b1, 4'b1110,
			1'b0, 16'h0000, 1'b0);
		add_row(CMD_VOL, 16'h0013, 16'h7000, 16'h9000, 16'h1000, 16'hF000, 1'b1, 4'b1110,
			1'b0, 16'h0000, 1'b0);
		// Clamping with signed and unsigned core samples
		add_row(CMD_VOL, 16'h0000, 16'h7FFF, 16'h8000, 16'h7FFF, 16'h8000, 1'b1, 4'b0101,
			1'b0, 16'h0000, 1'b0);
		add_row(NO_CMD, 16'h0000, 16'hFFFE, 16'h2000, 16'h4000, 16'h9000, 1'b0, 4'b0101,
			1'b0, 16'h0000, 1'b0);
		// One cycle glitch on the core samples
		add_row(NO_CMD, 16'h0000, 16'h0100, 16'h0100, 16'h0000, 16'h0000, 1'b1, 4'b0101,
			1'b1, 16'h4000, 1'b0);
		// LED overtake, mask 0x0F and state 0x05
		add_row(CMD_LED, 16'h0F05, 16'h0100, 16'h0100, 16'h0000, 16'h0000, 1'b1, 4'b0110,
			1'b0, 16'h0000, 1'b0);
		add_row(NO_CMD, 16'h0000, 16'h0100, 16'h0100, 16'h0000, 16'h0000, 1'b1, 4'b0000,
			1'b0, 16'h0000, 1'b0);
		// Separate sync, unknown command, then composite sync
		add_row(NO_CMD, 16'h0000, 16'h0100, 16'h0100, 16'h0000, 16'h0000, 1'b1, 4'b0000,
			1'b0, 16'h0000, 1'b1);
		add_row(8'h7E, 16'hFF1F, 16'h0100, 16'h0100, 16'h0000, 16'h0000, 1'b1, 4'b0000,
			1'b0, 16'h0000, 1'b1);
		add_row(CMD_CFG, 16'h0008, 16'h0100, 16'h0100, 16'h0000, 16'h0000, 1'b1, 4'b0000,
			1'b0, 16'h0000, 1'b1);
		// Shifts applied before the clamp
		add_row(CMD_VOL, 16'h0001, 16'h8000, 16'h0002, 16'h0100, 16'hFFFC, 1'b0, 4'b1110,
			1'b0, 16'h0000, 1'b0);
		add_row(CMD_VOL, 16'h0004, 16'h8000, 16'h7FFF, 16'h8000, 16'h7FFF, 1'b1, 4'b1110,
			1'b0, 16'h0000, 1'b0);
		add_row(NO_CMD, 16'h0000, 16'h2000, 16'h2000, 16'h0000, 16'h0000, 1'b0, 4'b1110,
			1'b1, 16'hE000, 1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// Host handshake
	////////////////////////////////////////////////////////////

	task automatic next_cycle;
		@(posedge clk_sys);
		#2;
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (o_io_ack !== level && n < ACK_LIMIT) begin
			next_cycle();
			n++;
		end
		if (o_io_ack !== level) begin
			$display("handshake failure: o_io_ack did not go to %0d within %0d cycles",
				level, ACK_LIMIT);
			hs_errors++;
		end
	endtask

	task automatic send_word(input logic [15:0] w);
		if (hs_errors == 0) begin
			i_io_din = w;
			next_cycle();
			i_io_clk = 1'b1;
			wait_ack(1'b1);
			i_io_clk = 1'b0;
			if (hs_errors == 0) wait_ack(1'b0);
		end
	endtask

	task automatic send_frame(input logic [7:0] cmd, input logic [15:0] data);
		next_cycle();
		i_io_uio = 1'b1;
		next_cycle();
		send_word({8'h00, cmd});
		send_word(data);
		i_io_uio = 1'b0;
		repeat (4) next_cycle();
	endtask

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	task automatic check_outputs(input row_t r);
		if (o_audio_l !== r.exp_l) begin
			$display("error o_audio_l: got %h expected %h (row %0d)", o_audio_l, r.exp_l,
				cur_row);
			val_errors++;
		end
		if (o_audio_r !== r.exp_r) begin
			$display("error o_audio_r: got %h expected %h (row %0d)", o_audio_r, r.exp_r,
				cur_row);
			val_errors++;
		end
		if (o_led_board !== r.exp_board) begin
			$display("error o_led_board: got %h expected %h (row %0d)", o_led_board,
				r.exp_board, cur_row);
			val_errors++;
		end
		if (o_led_power !== (r.led_p[1] & r.led_p[0])) begin
			$display("error o_led_power: got %h expected %h (row %0d)", o_led_power,
				r.led_p[1] & r.led_p[0], cur_row);
			val_errors++;
		end
		if (o_led_hdd !== r.led_d) begin
			$display("error o_led_hdd: got %h expected %h (row %0d)", o_led_hdd, r.led_d,
				cur_row);
			val_errors++;
		end
		if (o_led_user !== r.led_u) begin
			$display("error o_led_user: got %h expected %h (row %0d)", o_led_user, r.led_u,
				cur_row);
			val_errors++;
		end
	endtask

	// One full vs period, DUT registers the sync inputs once
	task automatic check_sync(input logic csync);
		logic hs_a;
		logic vs_a;
		logic exp_hs;
		logic exp_vs;
		repeat (VS_PER) begin
			@(negedge clk_sys);
			hs_a   = ~hs_prev;
			vs_a   = ~vs_prev;
			exp_hs = csync ? ~(hs_a ^ vs_a) : ~hs_a;
			exp_vs = csync ? 1'b1 : ~vs_a;
			if (o_vga_hs !== exp_hs) begin
				$display("error o_vga_hs: got %h expected %h (row %0d)", o_vga_hs, exp_hs,
					cur_row);
				val_errors++;
			end
			if (o_vga_vs !== exp_vs) begin
				$display("error o_vga_vs: got %h expected %h (row %0d)", o_vga_vs, exp_vs,
					cur_row);
				val_errors++;
			end
		end
	endtask

	task automatic apply_row(input row_t r);
		next_cycle();
		i_core_l       = r.core_l;
		i_core_r       = r.core_r;
		i_linux_l      = r.lin_l;
		i_linux_r      = r.lin_r;
		i_audio_signed = r.sgn;
		i_led_user     = r.led_u;
		i_led_power    = r.led_p;
		i_led_disk     = r.led_d;
		if (r.cmd != NO_CMD) send_frame(r.cmd, r.data);
		repeat (SETTLE) next_cycle();
		@(negedge clk_sys);
		check_outputs(r);
		if (r.glitch_en) begin
			next_cycle();
			i_core_l = r.glitch;
			i_core_r = r.glitch;
			next_cycle();
			i_core_l = r.core_l;
			i_core_r = r.core_r;
			repeat (SETTLE + 2) begin
				@(negedge clk_sys);
				check_outputs(r);
			end
		end
		if (r.chk_sync) check_sync(r.exp_csync);
	endtask

	task finish_run;
		$display("errors: %0d value, %0d handshake, %0d timeout", val_errors, hs_errors,
			timeouts);
		if (val_errors == 0 && hs_errors == 0 && timeouts == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and timeout
	////////////////////////////////////////////////////////////

	initial begin
		int k;
		resetd         = 1'b1;
		i_io_clk       = 1'b0;
		i_io_uio       = 1'b0;
		i_io_din       = '0;
		i_led_user     = 1'b0;
		i_led_power    = 2'b00;
		i_led_disk     = 1'b0;
		i_audio_signed = 1'b1;
		i_core_l       = '0;
		i_core_r       = '0;
		i_linux_l      = '0;
		i_linux_r      = '0;
		build_table();
		repeat (4) @(posedge clk_sys);
		#2;
		resetd = 1'b0;
		// Polarity detectors need two full sync periods
		repeat (2 * VS_PER + 4) next_cycle();
		for (k = 0; k < n_rows; k++) begin
			if (hs_errors != 0) break;
			cur_row = k;
			apply_row(rows[k]);
		end
		finish_run();
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run not complete after %0d cycles", TIMEOUT_CYCLES);
			timeouts = 1;
			finish_run();
		end
	end

endmodule

`default_nettype wire

// ==== video_sync_out.sv ====
/*
 * VGA sync output. Corrects hs and vs polarity and forms
 * separate or composite sync
 */
`timescale 1ns/100ps
`default_nettype none

module video_sync_out #(
	parameter int SYNC_CNT_W = sys_hal_pkg::SYNC_CNT_W_DEF
) (
	input  wire  clk_sys,
	input  wire  resetd,
	input  wire  i_hs,
	input  wire  i_vs,
	input  wire  i_csync_en,
	output logic o_vga_hs,
	output logic o_vga_vs
);
	logic hs_fix;
	logic vs_fix;

	sync_polarity_fix #(.SYNC_CNT_W(SYNC_CNT_W)) i_hs_fix (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs),
		.o_sync  (hs_fix)
	);

	sync_polarity_fix #(.SYNC_CNT_W(SYNC_CNT_W)) i_vs_fix (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs),
		.o_sync  (vs_fix)
	);

	// Composite sync on the hs pin, vs pin parked high
	assign o_vga_hs = i_csync_en ? ~(hs_fix ^ vs_fix) : ~hs_fix;
	assign o_vga_vs = i_csync_en ? 1'b1 : ~vs_fix;

endmodule

`default_nettype wire
